// File: filelist.f
+incdir+rtl
rtl/exu_pkg.sv
rtl/exu_alu.sv
rtl/exu_bru.sv
rtl/div_ctrl.sv
rtl/div_iter_counter.sv
rtl/div_datapath.sv
rtl/exu.sv
verif/tb_exu.sv

// File: Makefile
# Verilator flow for the execution lane

TOP := tb_exu
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f filelist.f --top-module exu

sim:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: verif/tb_exu.sv
// testbench for the execution lane
// table of ALU, divider and branch cases checked against a behavioral model,
// plus back-pressure holds, interrupt jump and interrupt cancel

`timescale 1ns/1ps
`include "exu_settings.svh"

module tb_exu
    import exu_pkg::*;
();

    localparam int CLK_PERIOD  = 100;
    localparam int TABLE_MAX   = 96;
    localparam int HOLD_CYCLES = 5;
    localparam int LANE_ALU    = 0;
    localparam int LANE_DIV    = 1;
    localparam int LANE_BJP    = 2;

    logic clk = 1'b0;
    logic arst_n, int_assert, int_jump;
    logic [31:0] int_addr;
    logic req_alu, alu_wb_ready, req_div, div_wb_ready, req_bjp;
    logic [31:0] alu_op1, alu_op2, div_op1, div_op2;
    logic [31:0] bjp_op1, bjp_op2, bjp_jop1, bjp_jop2;
    alu_op_e alu_op;
    div_op_e div_op;
    bjp_op_e bjp_op;
    logic [4:0] alu_rd, div_rd;
    logic [2:0] alu_cid, div_cid;
    logic alu_we, div_we, stall, jump_flag, misaligned;
    logic [31:0] alu_wdata, div_wdata, jump_addr;
    logic [4:0] alu_waddr, div_waddr;
    logic [2:0] alu_cid_o, div_cid_o;

    // stimulus table, one row per case
    int          t_lane [TABLE_MAX];
    logic [3:0]  t_op [TABLE_MAX];
    logic [31:0] t_a [TABLE_MAX];
    logic [31:0] t_b [TABLE_MAX];
    logic [31:0] t_ja [TABLE_MAX];
    logic [31:0] t_jb [TABLE_MAX];
    logic [31:0] t_exp [TABLE_MAX];
    logic        t_exp_flag [TABLE_MAX];
    logic        t_exp_mis [TABLE_MAX];
    int          n_entries = 0;
    int          errors = 0;
    integer      seed;
    logic        table_ready = 1'b0;

    exu dut (
        .clk(clk), .arst_n_i(arst_n), .int_assert_i(int_assert),
        .int_jump_i(int_jump), .int_addr_i(int_addr),
        .req_alu_i(req_alu), .alu_op1_i(alu_op1), .alu_op2_i(alu_op2), .alu_op_i(alu_op),
        .alu_rd_i(alu_rd), .alu_commit_id_i(alu_cid), .alu_wb_ready_i(alu_wb_ready),
        .req_div_i(req_div), .div_op1_i(div_op1), .div_op2_i(div_op2), .div_op_i(div_op),
        .div_rd_i(div_rd), .div_commit_id_i(div_cid), .div_wb_ready_i(div_wb_ready),
        .req_bjp_i(req_bjp), .bjp_op1_i(bjp_op1), .bjp_op2_i(bjp_op2),
        .bjp_jump_op1_i(bjp_jop1), .bjp_jump_op2_i(bjp_jop2), .bjp_op_i(bjp_op),
        .alu_reg_we_o(alu_we), .alu_reg_wdata_o(alu_wdata), .alu_reg_waddr_o(alu_waddr),
        .alu_commit_id_o(alu_cid_o), .div_reg_we_o(div_we), .div_reg_wdata_o(div_wdata),
        .div_reg_waddr_o(div_waddr), .div_commit_id_o(div_cid_o), .stall_flag_o(stall),
        .jump_flag_o(jump_flag), .jump_addr_o(jump_addr), .misaligned_fetch_o(misaligned)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] alu_model(alu_op_e op, logic [31:0] a, logic [31:0] b);
        case (op)
            alu_add:  return a + b;
            alu_sub:  return a - b;
            alu_sll:  return a << b[4:0];
            alu_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            alu_sltu: return (a < b) ? 32'd1 : 32'd0;
            alu_xor:  return a ^ b;
            alu_srl:  return a >> b[4:0];
            alu_sra:  return $signed(a) >>> b[4:0];
            alu_or:   return a | b;
            default:  return a & b;
        endcase
    endfunction

    // RISC-V rules: x/0 is all ones with remainder x, MIN/-1 overflows to MIN rem 0
    function automatic logic [31:0] div_model(div_op_e op, logic [31:0] a, logic [31:0] b);
        logic [31:0] q;
        logic [31:0] r;
        if (b == 32'd0) begin
            q = '1;
            r = a;
        end else if (op == div_op_divu || op == div_op_remu) begin
            q = a / b;
            r = a % b;
        end else if (a == 32'h8000_0000 && b == 32'hffff_ffff) begin
            q = a;
            r = 32'd0;
        end else begin
            q = $signed(a) / $signed(b);
            r = $signed(a) % $signed(b);
        end
        return (op == div_op_rem || op == div_op_remu) ? r : q;
    endfunction

    function automatic logic branch_taken(bjp_op_e op, logic [31:0] a, logic [31:0] b);
        case (op)
            bjp_beq:  return a == b;
            bjp_bne:  return a != b;
            bjp_blt:  return $signed(a) < $signed(b);
            bjp_bge:  return $signed(a) >= $signed(b);
            bjp_bltu: return a < b;
            bjp_bgeu: return a >= b;
            default:  return 1'b1;
        endcase
    endfunction

    function automatic logic [31:0] branch_target(bjp_op_e op, logic [31:0] ja, logic [31:0] jb);
        logic [31:0] t;
        t = ja + jb;
        if (op == bjp_jalr) begin
            t[0] = 1'b0;
        end
        return t;
    endfunction

    task automatic add_entry(int lane, logic [3:0] op, logic [31:0] a, logic [31:0] b,
                             logic [31:0] ja, logic [31:0] jb);
        t_lane[n_entries] = lane;
        t_op[n_entries]   = op;
        t_a[n_entries]    = a;
        t_b[n_entries]    = b;
        t_ja[n_entries]   = ja;
        t_jb[n_entries]   = jb;
        t_exp_flag[n_entries] = 1'b0;
        t_exp_mis[n_entries]  = 1'b0;
        if (lane == LANE_ALU) begin
            t_exp[n_entries] = alu_model(alu_op_e'(op), a, b);
        end else if (lane == LANE_DIV) begin
            t_exp[n_entries] = div_model(div_op_e'(op[1:0]), a, b);
        end else begin
            t_exp[n_entries]      = branch_target(bjp_op_e'(op[2:0]), ja, jb);
            t_exp_flag[n_entries] = branch_taken(bjp_op_e'(op[2:0]), a, b);
            t_exp_mis[n_entries]  = t_exp_flag[n_entries] & t_exp[n_entries][1];
        end
        n_entries++;
    endtask

    task automatic build_table();
        logic [31:0] a;
        logic [31:0] b;
        for (int op = 0; op < 10; op++) begin
            add_entry(LANE_ALU, 4'(op), 32'h8000_0001, 32'h0000_0023, '0, '0);
            add_entry(LANE_ALU, 4'(op), 32'h7fff_ffff, 32'hffff_fffe, '0, '0);
            add_entry(LANE_ALU, 4'(op), 32'h0f0f_1234, 32'h0000_0007, '0, '0);
        end
        for (int op = 0; op < 4; op++) begin
            add_entry(LANE_DIV, 4'(op), 32'd100, 32'd7, '0, '0);
            add_entry(LANE_DIV, 4'(op), 32'hffff_ff9c, 32'd7, '0, '0);
            add_entry(LANE_DIV, 4'(op), 32'hffff_fff9, 32'hffff_fffe, '0, '0);
            add_entry(LANE_DIV, 4'(op), 32'd12345, 32'd0, '0, '0);
            add_entry(LANE_DIV, 4'(op), 32'h8000_0000, 32'hffff_ffff, '0, '0);
        end
        for (int k = 0; k < 12; k++) begin
            a = $random(seed);
            b = $random(seed);
            // small divisors give wide quotients
            if (k % 3 == 1) begin
                b = b >> 20;
            end
            add_entry(LANE_DIV, 4'($random(seed) & 3), a, b, '0, '0);
        end
        add_entry(LANE_BJP, 4'(bjp_jal), '0, '0, 32'h0000_0100, 32'h0000_0020);
        add_entry(LANE_BJP, 4'(bjp_jal), '0, '0, 32'h0000_0100, 32'h0000_0002);
        add_entry(LANE_BJP, 4'(bjp_jalr), '0, '0, 32'h0000_1000, 32'h0000_0005);
        add_entry(LANE_BJP, 4'(bjp_jalr), '0, '0, 32'h0000_1000, 32'h0000_0007);
        for (int op = 2; op < 8; op++) begin
            add_entry(LANE_BJP, 4'(op), 32'd5, 32'd5, 32'h0000_2000, 32'h0000_0010);
            add_entry(LANE_BJP, 4'(op), 32'hffff_fffe, 32'd3, 32'h0000_2000, 32'h0000_0012);
            add_entry(LANE_BJP, 4'(op), 32'd3, 32'hffff_fffe, 32'h0000_2000, 32'h0000_0012);
        end
    endtask

    task automatic report_mismatch(string what, logic [31:0] got, logic [31:0] exp);
        errors++;
        $display("FAIL at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
    endtask

    task automatic alu_entry(int i, logic hold);
        @(posedge clk);
        req_alu      <= 1'b1;
        alu_op1      <= t_a[i];
        alu_op2      <= t_b[i];
        alu_op       <= alu_op_e'(t_op[i]);
        alu_rd       <= 5'(i);
        alu_cid      <= 3'(i);
        alu_wb_ready <= !hold;
        @(posedge clk);
        req_alu <= 1'b0;
        @(negedge clk);
        if (alu_we !== 1'b1) report_mismatch($sformatf("entry %0d alu we", i), 32'(alu_we), 1);
        if (alu_wdata !== t_exp[i]) report_mismatch($sformatf("entry %0d alu data", i),
                                                    alu_wdata, t_exp[i]);
        if (alu_waddr !== 5'(i) || alu_cid_o !== 3'(i)) begin
            report_mismatch($sformatf("entry %0d alu rd/tag", i), {alu_waddr, alu_cid_o},
                            {5'(i), 3'(i)});
        end
        if (hold) begin
            repeat (HOLD_CYCLES) begin
                @(negedge clk);
                if (alu_we !== 1'b1 || alu_wdata !== t_exp[i] || stall !== 1'b1) begin
                    report_mismatch($sformatf("entry %0d alu hold", i), alu_wdata, t_exp[i]);
                end
            end
            @(posedge clk);
            alu_wb_ready <= 1'b1;
        end
        @(posedge clk);
        @(negedge clk);
        if (alu_we !== 1'b0 || stall !== 1'b0) report_mismatch(
            $sformatf("entry %0d alu retire we/stall", i), {alu_we, stall}, 0);
    endtask

    task automatic div_entry(int i, logic hold);
        int n;
        @(posedge clk);
        req_div      <= 1'b1;
        div_op1      <= t_a[i];
        div_op2      <= t_b[i];
        div_op       <= div_op_e'(t_op[i][1:0]);
        div_rd       <= 5'(i);
        div_cid      <= 3'(i + 1);
        div_wb_ready <= !hold;
        @(posedge clk);
        req_div <= 1'b0;
        n = 0;
        @(negedge clk);
        while (div_we !== 1'b1 && n <= `DIV_CYCLES + 8) begin
            if (stall !== 1'b1) report_mismatch($sformatf("entry %0d div stall", i), 0, 1);
            n++;
            @(negedge clk);
        end
        if (div_we !== 1'b1) begin
            errors++;
            $display("divider entry %0d never raised its write-back", i);
        end else begin
            if (n != `DIV_CYCLES + 1) report_mismatch($sformatf("entry %0d div latency", i),
                                                      32'(n), 32'(`DIV_CYCLES + 1));
            if (div_wdata !== t_exp[i]) report_mismatch($sformatf("entry %0d div data", i),
                                                        div_wdata, t_exp[i]);
            if (div_waddr !== 5'(i) || div_cid_o !== 3'(i + 1)) begin
                report_mismatch($sformatf("entry %0d div rd/tag", i), {div_waddr, div_cid_o},
                                {5'(i), 3'(i + 1)});
            end
        end
        if (hold) begin
            repeat (HOLD_CYCLES) begin
                @(negedge clk);
                if (div_we !== 1'b1 || div_wdata !== t_exp[i] || stall !== 1'b1) begin
                    report_mismatch($sformatf("entry %0d div hold", i), div_wdata, t_exp[i]);
                end
            end
            @(posedge clk);
            div_wb_ready <= 1'b1;
        end
        @(posedge clk);
        @(negedge clk);
        if (div_we !== 1'b0 || stall !== 1'b0) report_mismatch(
            $sformatf("entry %0d div retire we/stall", i), {div_we, stall}, 0);
    endtask

    task automatic branch_entry(int i);
        @(posedge clk);
        req_bjp  <= 1'b1;
        bjp_op1  <= t_a[i];
        bjp_op2  <= t_b[i];
        bjp_jop1 <= t_ja[i];
        bjp_jop2 <= t_jb[i];
        bjp_op   <= bjp_op_e'(t_op[i][2:0]);
        @(negedge clk);
        if (jump_flag !== t_exp_flag[i]) report_mismatch($sformatf("entry %0d jump flag", i),
                                                         32'(jump_flag), 32'(t_exp_flag[i]));
        if (jump_addr !== t_exp[i]) report_mismatch($sformatf("entry %0d jump addr", i),
                                                    jump_addr, t_exp[i]);
        if (misaligned !== t_exp_mis[i]) report_mismatch($sformatf("entry %0d misaligned", i),
                                                         32'(misaligned), 32'(t_exp_mis[i]));
        @(posedge clk);
        req_bjp <= 1'b0;
    endtask

    // interrupt address wins over a misaligned jalr in the same cycle
    task automatic interrupt_jump_test();
        @(posedge clk);
        int_jump <= 1'b1;
        int_addr <= 32'h0000_0800;
        req_bjp  <= 1'b1;
        bjp_op   <= bjp_jalr;
        bjp_jop1 <= 32'h0000_3000;
        bjp_jop2 <= 32'h0000_0003;
        @(negedge clk);
        if (jump_flag !== 1'b1) report_mismatch("int jump flag", 32'(jump_flag), 1);
        if (jump_addr !== 32'h0000_0800) report_mismatch("int jump addr", jump_addr, 32'h800);
        if (misaligned !== 1'b0) report_mismatch("int jump misaligned", 32'(misaligned), 0);
        @(posedge clk);
        int_jump <= 1'b0;
        req_bjp  <= 1'b0;
    endtask

    task automatic interrupt_cancel_test();
        @(posedge clk);
        req_alu      <= 1'b1;
        alu_op       <= alu_add;
        alu_op1      <= 32'd3;
        alu_op2      <= 32'd4;
        alu_wb_ready <= 1'b0;
        @(posedge clk);
        req_alu <= 1'b0;
        req_div <= 1'b1;
        div_op  <= div_op_divu;
        div_op1 <= 32'd1000;
        div_op2 <= 32'd3;
        @(posedge clk);
        req_div <= 1'b0;
        repeat (10) @(negedge clk);
        if (stall !== 1'b1 || alu_we !== 1'b1) report_mismatch("busy before cancel",
                                                               {stall, alu_we}, 32'b11);
        @(posedge clk);
        int_assert <= 1'b1;
        @(posedge clk);
        int_assert <= 1'b0;
        @(negedge clk);
        if (stall !== 1'b0 || alu_we !== 1'b0) report_mismatch("stall/alu we after cancel",
                                                               {stall, alu_we}, 0);
        repeat (`DIV_CYCLES + 5) begin
            @(negedge clk);
            if (div_we !== 1'b0) report_mismatch("div write-back after cancel", 32'(div_we), 0);
        end
        @(posedge clk);
        alu_wb_ready <= 1'b1;
    endtask

    initial begin
        seed         = 32'h58cd_d79e;
        arst_n       = 1'b0;
        int_assert   = 1'b0;
        int_jump     = 1'b0;
        int_addr     = '0;
        req_alu      = 1'b0;
        alu_op1      = '0;
        alu_op2      = '0;
        alu_op       = alu_add;
        alu_rd       = '0;
        alu_cid      = '0;
        alu_wb_ready = 1'b1;
        req_div      = 1'b0;
        div_op1      = '0;
        div_op2      = '0;
        div_op       = div_op_div;
        div_rd       = '0;
        div_cid      = '0;
        div_wb_ready = 1'b1;
        req_bjp      = 1'b0;
        bjp_op1      = '0;
        bjp_op2      = '0;
        bjp_jop1     = '0;
        bjp_jop2     = '0;
        bjp_op       = bjp_jal;
        build_table();
        table_ready = 1'b1;
        repeat (16) @(posedge clk);
        arst_n <= 1'b1;
        for (int i = 0; i < n_entries; i++) begin
            if (t_lane[i] == LANE_ALU) begin
                alu_entry(i, i % 5 == 2);
            end else if (t_lane[i] == LANE_DIV) begin
                div_entry(i, i % 5 == 2);
            end else begin
                branch_entry(i);
            end
        end
        interrupt_jump_test();
        interrupt_cancel_test();
        $display("entries run: %0d, errors: %0d", n_entries, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // budget per table entry covers one full division plus hold
    initial begin
        wait (table_ready);
        #((n_entries * (`DIV_CYCLES + 10) + 200) * CLK_PERIOD);
        $display("watchdog expired before the tests finished");
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

// File: rtl/exu.sv
// execution unit, single issue lane
// integer ALU, branch resolver and iterative divider behind one stall flag

`timescale 1ns/1ps
`include "exu_settings.svh"

module exu
    import exu_pkg::*;
(
    input  logic                        clk,
    input  logic                        arst_n_i,
    input  logic                        int_assert_i,
    input  logic                        int_jump_i,
    input  logic [`XLEN-1:0]            int_addr_i,

    input  logic                        req_alu_i,
    input  logic [`XLEN-1:0]            alu_op1_i,
    input  logic [`XLEN-1:0]            alu_op2_i,
    input  alu_op_e                     alu_op_i,
    input  logic [`REG_ADDR_WIDTH-1:0]  alu_rd_i,
    input  logic [`COMMIT_ID_WIDTH-1:0] alu_commit_id_i,
    input  logic                        alu_wb_ready_i,

    input  logic                        req_div_i,
    input  logic [`XLEN-1:0]            div_op1_i,
    input  logic [`XLEN-1:0]            div_op2_i,
    input  div_op_e                     div_op_i,
    input  logic [`REG_ADDR_WIDTH-1:0]  div_rd_i,
    input  logic [`COMMIT_ID_WIDTH-1:0] div_commit_id_i,
    input  logic                        div_wb_ready_i,

    input  logic                        req_bjp_i,
    input  logic [`XLEN-1:0]            bjp_op1_i,
    input  logic [`XLEN-1:0]            bjp_op2_i,
    input  logic [`XLEN-1:0]            bjp_jump_op1_i,
    input  logic [`XLEN-1:0]            bjp_jump_op2_i,
    input  bjp_op_e                     bjp_op_i,

    output logic                        alu_reg_we_o,
    output logic [`XLEN-1:0]            alu_reg_wdata_o,
    output logic [`REG_ADDR_WIDTH-1:0]  alu_reg_waddr_o,
    output logic [`COMMIT_ID_WIDTH-1:0] alu_commit_id_o,
    output logic                        div_reg_we_o,
    output logic [`XLEN-1:0]            div_reg_wdata_o,
    output logic [`REG_ADDR_WIDTH-1:0]  div_reg_waddr_o,
    output logic [`COMMIT_ID_WIDTH-1:0] div_commit_id_o,
    output logic                        stall_flag_o,
    output logic                        jump_flag_o,
    output logic [`XLEN-1:0]            jump_addr_o,
    output logic                        misaligned_fetch_o
);

    logic alu_stall;
    logic div_stall;
    logic div_load;
    logic div_start;
    logic div_step;
    logic div_last;

    exu_alu u_alu (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .int_assert_i   (int_assert_i),
        .req_alu_i      (req_alu_i),
        .alu_op1_i      (alu_op1_i),
        .alu_op2_i      (alu_op2_i),
        .alu_op_i       (alu_op_i),
        .alu_rd_i       (alu_rd_i),
        .alu_commit_id_i(alu_commit_id_i),
        .wb_ready_i     (alu_wb_ready_i),
        .reg_we_o       (alu_reg_we_o),
        .reg_wdata_o    (alu_reg_wdata_o),
        .reg_waddr_o    (alu_reg_waddr_o),
        .commit_id_o    (alu_commit_id_o),
        .stall_o        (alu_stall)
    );

    exu_bru u_bru (
        .req_bjp_i         (req_bjp_i),
        .bjp_op1_i         (bjp_op1_i),
        .bjp_op2_i         (bjp_op2_i),
        .bjp_jump_op1_i    (bjp_jump_op1_i),
        .bjp_jump_op2_i    (bjp_jump_op2_i),
        .bjp_op_i          (bjp_op_i),
        .int_jump_i        (int_jump_i),
        .int_addr_i        (int_addr_i),
        .jump_flag_o       (jump_flag_o),
        .jump_addr_o       (jump_addr_o),
        .misaligned_fetch_o(misaligned_fetch_o)
    );

    div_ctrl u_div_ctrl (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .int_assert_i(int_assert_i),
        .req_div_i   (req_div_i),
        .last_i      (div_last),
        .wb_ready_i  (div_wb_ready_i),
        .load_o      (div_load),
        .start_o     (div_start),
        .step_o      (div_step),
        .reg_we_o    (div_reg_we_o),
        .stall_o     (div_stall)
    );

    div_iter_counter u_div_cnt (
        .clk     (clk),
        .arst_n_i(arst_n_i),
        .start_i (div_start),
        .step_i  (div_step),
        .last_o  (div_last)
    );

    div_datapath u_div_dp (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .load_i         (div_load),
        .step_i         (div_step),
        .div_op1_i      (div_op1_i),
        .div_op2_i      (div_op2_i),
        .div_op_i       (div_op_i),
        .div_rd_i       (div_rd_i),
        .div_commit_id_i(div_commit_id_i),
        .reg_wdata_o    (div_reg_wdata_o),
        .reg_waddr_o    (div_reg_waddr_o),
        .commit_id_o    (div_commit_id_o)
    );

    // either lane holding up issue stalls the pipeline
    assign stall_flag_o = alu_stall | div_stall;

endmodule

// File: rtl/div_datapath.sv
// divider datapath
// restoring shift-subtract on operand magnitudes, one quotient bit per step;
// signs are applied when the result is read out

`timescale 1ns/1ps
`include "exu_settings.svh"

module div_datapath
    import exu_pkg::*;
(
    input  logic                        clk,
    input  logic                        arst_n_i,
    input  logic                        load_i,
    input  logic                        step_i,
    input  logic [`XLEN-1:0]            div_op1_i,
    input  logic [`XLEN-1:0]            div_op2_i,
    input  div_op_e                     div_op_i,
    input  logic [`REG_ADDR_WIDTH-1:0]  div_rd_i,
    input  logic [`COMMIT_ID_WIDTH-1:0] div_commit_id_i,
    output logic [`XLEN-1:0]            reg_wdata_o,
    output logic [`REG_ADDR_WIDTH-1:0]  reg_waddr_o,
    output logic [`COMMIT_ID_WIDTH-1:0] commit_id_o
);

    logic             is_signed;
    logic             op1_neg;
    logic             op2_neg;
    logic [`XLEN-1:0] op1_abs;
    logic [`XLEN-1:0] op2_abs;

    logic [`XLEN-1:0] quot_q;
    logic [`XLEN-1:0] rem_q;
    logic [`XLEN-1:0] divisor_q;
    logic             neg_quot_q;
    logic             neg_rem_q;
    div_op_e          op_q;

    logic [`XLEN:0]   rem_shift;
    logic [`XLEN:0]   rem_diff;
    logic             fits;

    logic [`XLEN-1:0] quot_res;
    logic [`XLEN-1:0] rem_res;

    assign is_signed = (div_op_i == div_op_div) || (div_op_i == div_op_rem);
    assign op1_neg   = is_signed & div_op1_i[`XLEN-1];
    assign op2_neg   = is_signed & div_op2_i[`XLEN-1];
    assign op1_abs   = op1_neg ? -div_op1_i : div_op1_i;
    assign op2_abs   = op2_neg ? -div_op2_i : div_op2_i;

    // next dividend bit shifted into the partial remainder
    assign rem_shift = {rem_q, quot_q[`XLEN-1]};
    assign rem_diff  = rem_shift - {1'b0, divisor_q};
    assign fits      = (rem_shift >= {1'b0, divisor_q});

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            quot_q      <= '0;
            rem_q       <= '0;
            divisor_q   <= '0;
            neg_quot_q  <= 1'b0;
            neg_rem_q   <= 1'b0;
            op_q        <= div_op_div;
            reg_waddr_o <= '0;
            commit_id_o <= '0;
        end else if (load_i) begin
            quot_q      <= op1_abs;
            rem_q       <= '0;
            divisor_q   <= op2_abs;
            // x/0 must read as all ones, so its quotient never flips sign
            neg_quot_q  <= (op1_neg ^ op2_neg) & (div_op2_i != '0);
            neg_rem_q   <= op1_neg;
            op_q        <= div_op_i;
            reg_waddr_o <= div_rd_i;
            commit_id_o <= div_commit_id_i;
        end else if (step_i) begin
            quot_q <= {quot_q[`XLEN-2:0], fits};
            rem_q  <= fits ? rem_diff[`XLEN-1:0] : rem_shift[`XLEN-1:0];
        end
    end

    // a zero divisor fits every step: quotient all ones, remainder the dividend
    // most negative / -1 gives magnitude 2^(XLEN-1), which negates back onto itself
    assign quot_res = neg_quot_q ? -quot_q : quot_q;
    assign rem_res  = neg_rem_q ? -rem_q : rem_q;

    assign reg_wdata_o = ((op_q == div_op_rem) || (op_q == div_op_remu)) ? rem_res : quot_res;

endmodule

// File: rtl/div_iter_counter.sv
// divider iteration counter
// counts step pulses from a start and flags the final one

`timescale 1ns/1ps
`include "exu_settings.svh"

module div_iter_counter (
    input  logic clk,
    input  logic arst_n_i,
    input  logic start_i,
    input  logic step_i,
    output logic last_o
);

    typedef logic [$clog2(`DIV_CYCLES)-1:0] cnt_t;

    cnt_t cnt_q;

    // last_o rises with the DIV_CYCLES-th step and holds until the next start
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cnt_q  <= '0;
            last_o <= 1'b0;
        end else if (start_i) begin
            cnt_q  <= '0;
            last_o <= 1'b0;
        end else if (step_i) begin
            cnt_q  <= cnt_q + cnt_t'(1);
            last_o <= (cnt_q == cnt_t'(`DIV_CYCLES - 1));
        end
    end

endmodule

// File: rtl/div_ctrl.sv
// divider FSM
// sequences operand load, the iteration steps and the held result,
// and returns to idle on an interrupt

`timescale 1ns/1ps

module div_ctrl
    import exu_pkg::*;
(
    input  logic clk,
    input  logic arst_n_i,
    input  logic int_assert_i,
    input  logic req_div_i,
    input  logic last_i,
    input  logic wb_ready_i,
    output logic load_o,
    output logic start_o,
    output logic step_o,
    output logic reg_we_o,
    output logic stall_o
);

    div_state_e state_q;
    div_state_e state_d;

    always_comb begin
        state_d = state_q;
        case (state_q)
            div_st_idle: begin
                if (req_div_i) begin
                    state_d = div_st_busy;
                end
            end
            div_st_busy: begin
                if (last_i) begin
                    state_d = div_st_done;
                end
            end
            div_st_done: begin
                if (wb_ready_i) begin
                    state_d = div_st_idle;
                end
            end
            default: state_d = div_st_idle;
        endcase
        if (int_assert_i) begin
            state_d = div_st_idle;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= div_st_idle;
        end else begin
            state_q <= state_d;
        end
    end

    assign load_o  = (state_q == div_st_idle) & req_div_i & ~int_assert_i;
    assign start_o = load_o;
    // last_i comes up after the final step and that cycle only moves to done
    assign step_o   = (state_q == div_st_busy) & ~last_i;
    assign reg_we_o = (state_q == div_st_done);
    assign stall_o  = (state_q != div_st_idle);

    a_req_only_in_idle: assert property (
        @(posedge clk) disable iff (!arst_n_i) (state_q != div_st_idle) |-> !req_div_i
    );

    // done must follow a fresh rise of last_i from the counter
    a_done_after_last: assert property (
        @(posedge clk) disable iff (!arst_n_i)
            $rose(state_q == div_st_done) |-> $past(last_i) && !$past(last_i, 2)
    );

endmodule

// File: rtl/exu_bru.sv
// branch and jump resolver
// evaluates the branch condition and target in the same cycle,
// lets an interrupt jump override it and flags misaligned targets

`timescale 1ns/1ps
`include "exu_settings.svh"

module exu_bru
    import exu_pkg::*;
(
    input  logic             req_bjp_i,
    input  logic [`XLEN-1:0] bjp_op1_i,
    input  logic [`XLEN-1:0] bjp_op2_i,
    input  logic [`XLEN-1:0] bjp_jump_op1_i,
    input  logic [`XLEN-1:0] bjp_jump_op2_i,
    input  bjp_op_e          bjp_op_i,
    input  logic             int_jump_i,
    input  logic [`XLEN-1:0] int_addr_i,
    output logic             jump_flag_o,
    output logic [`XLEN-1:0] jump_addr_o,
    output logic             misaligned_fetch_o
);

    logic             taken;
    logic             branch_jump;
    logic [`XLEN-1:0] target;

    always_comb begin
        case (bjp_op_i)
            bjp_jal,
            bjp_jalr: taken = 1'b1;
            bjp_beq:  taken = (bjp_op1_i == bjp_op2_i);
            bjp_bne:  taken = (bjp_op1_i != bjp_op2_i);
            bjp_blt:  taken = ($signed(bjp_op1_i) < $signed(bjp_op2_i));
            bjp_bge:  taken = ($signed(bjp_op1_i) >= $signed(bjp_op2_i));
            bjp_bltu: taken = (bjp_op1_i < bjp_op2_i);
            bjp_bgeu: taken = (bjp_op1_i >= bjp_op2_i);
            default:  taken = 1'b0;
        endcase
    end

    always_comb begin
        target = bjp_jump_op1_i + bjp_jump_op2_i;
        // jalr drops the low bit of rs1 + imm
        if (bjp_op_i == bjp_jalr) begin
            target[0] = 1'b0;
        end
    end

    assign branch_jump = req_bjp_i & taken;

    assign jump_flag_o = int_jump_i | branch_jump;
    assign jump_addr_o = int_jump_i ? int_addr_i : target;

    // no compressed support, so bit 1 of a taken target is a fault
    assign misaligned_fetch_o = branch_jump & ~int_jump_i & target[1];

endmodule

// File: rtl/exu_alu.sv
// integer ALU
// computes one operation per request and registers the result with its tag;
// the write-back stays valid until the write-back stage accepts it

`timescale 1ns/1ps
`include "exu_settings.svh"

module exu_alu
    import exu_pkg::*;
(
    input  logic                        clk,
    input  logic                        arst_n_i,
    input  logic                        int_assert_i,
    input  logic                        req_alu_i,
    input  logic [`XLEN-1:0]            alu_op1_i,
    input  logic [`XLEN-1:0]            alu_op2_i,
    input  alu_op_e                     alu_op_i,
    input  logic [`REG_ADDR_WIDTH-1:0]  alu_rd_i,
    input  logic [`COMMIT_ID_WIDTH-1:0] alu_commit_id_i,
    input  logic                        wb_ready_i,
    output logic                        reg_we_o,
    output logic [`XLEN-1:0]            reg_wdata_o,
    output logic [`REG_ADDR_WIDTH-1:0]  reg_waddr_o,
    output logic [`COMMIT_ID_WIDTH-1:0] commit_id_o,
    output logic                        stall_o
);

    logic [`XLEN-1:0] result;
    logic [4:0]       shamt;

    assign shamt = alu_op2_i[4:0];

    always_comb begin
        case (alu_op_i)
            alu_add:  result = alu_op1_i + alu_op2_i;
            alu_sub:  result = alu_op1_i - alu_op2_i;
            alu_sll:  result = alu_op1_i << shamt;
            alu_slt:  result = {{(`XLEN-1){1'b0}}, $signed(alu_op1_i) < $signed(alu_op2_i)};
            alu_sltu: result = {{(`XLEN-1){1'b0}}, alu_op1_i < alu_op2_i};
            alu_xor:  result = alu_op1_i ^ alu_op2_i;
            alu_srl:  result = alu_op1_i >> shamt;
            alu_sra:  result = $signed(alu_op1_i) >>> shamt;
            alu_or:   result = alu_op1_i | alu_op2_i;
            alu_and:  result = alu_op1_i & alu_op2_i;
            default:  result = '0;
        endcase
    end

    // valid flag, a new request wins over retirement on the same edge
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            reg_we_o <= 1'b0;
        end else if (int_assert_i) begin
            reg_we_o <= 1'b0;
        end else if (req_alu_i) begin
            reg_we_o <= 1'b1;
        end else if (wb_ready_i) begin
            reg_we_o <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            reg_wdata_o <= '0;
            reg_waddr_o <= '0;
            commit_id_o <= '0;
        end else if (req_alu_i) begin
            reg_wdata_o <= result;
            reg_waddr_o <= alu_rd_i;
            commit_id_o <= alu_commit_id_i;
        end
    end

    // held result not yet taken
    assign stall_o = reg_we_o & ~wb_ready_i;

    // issue must wait while a result is blocked at write-back
    a_no_req_when_stalled: assert property (
        @(posedge clk) disable iff (!arst_n_i) stall_o |-> !req_alu_i
    );

endmodule

// File: rtl/exu_pkg.sv
// execution lane types
// operation encodings for the ALU, branch unit and divider, plus divider FSM states

package exu_pkg;

    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_sll  = 4'd2,
        alu_slt  = 4'd3,
        alu_sltu = 4'd4,
        alu_xor  = 4'd5,
        alu_srl  = 4'd6,
        alu_sra  = 4'd7,
        alu_or   = 4'd8,
        alu_and  = 4'd9
    } alu_op_e;

    typedef enum logic [2:0] {
        bjp_jal  = 3'd0,
        bjp_jalr = 3'd1,
        bjp_beq  = 3'd2,
        bjp_bne  = 3'd3,
        bjp_blt  = 3'd4,
        bjp_bge  = 3'd5,
        bjp_bltu = 3'd6,
        bjp_bgeu = 3'd7
    } bjp_op_e;

    typedef enum logic [1:0] {
        div_op_div  = 2'd0,
        div_op_divu = 2'd1,
        div_op_rem  = 2'd2,
        div_op_remu = 2'd3
    } div_op_e;

    typedef enum logic [1:0] {
        div_st_idle = 2'd0,
        div_st_busy = 2'd1,
        div_st_done = 2'd2
    } div_state_e;

endpackage

// File: rtl/exu_settings.svh
// execution lane settings
// widths and iteration count shared by the ALU, branch and divider blocks

`ifndef EXU_SETTINGS_SVH
`define EXU_SETTINGS_SVH

// operand and result width
`define XLEN 32

// destination register address
`define REG_ADDR_WIDTH 5

// commit tag carried with every write-back
`define COMMIT_ID_WIDTH 3

// one quotient bit per iteration, so this tracks XLEN
`define DIV_CYCLES 32

`endif
